// File: src/memPkg.sv
package memPkg;

    // issue width, the highest lane index holds the oldest instruction
    localparam int LANES = 2;
    localparam int LANE_BITS = (LANES > 1) ? $clog2(LANES) : 1;

    // kseg1-style uncached window marker
    localparam int UNCACHED_BIT = 29;

    localparam int WORD_BYTES = 4;

    typedef logic [31:0] word_t;
    typedef logic [WORD_BYTES-1:0] strobe_t;
    typedef logic [4:0] dest_t;

    // access width as carried on the data bus
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } msize_t;

    // control-transfer kind coming out of execute
    typedef enum logic [1:0] {
        CT_NONE      = 2'd0,
        CT_EXCEPTION = 2'd1,
        CT_ERET      = 2'd2
    } ctype_t;

    // either kind flushes everything younger in the group
    function automatic logic isTrap(input ctype_t ct);
        return (ct == CT_EXCEPTION) || (ct == CT_ERET);
    endfunction

endpackage

// File: src/storeFormat.sv
`timescale 1ns/1ns

module storeFormat import memPkg::*; (
    input  logic [1:0] addrLow,
    input  msize_t     size,
    input  word_t      data,
    output word_t      shifted,
    output strobe_t    strobe
);

    // data is replicated into every lane, the strobe picks the live bytes
    always_comb begin
        case (size)
            SIZE_BYTE: begin
                shifted = {4{data[7:0]}};
                strobe = strobe_t'(1) << addrLow;
            end
            SIZE_HALF: begin
                shifted = {2{data[15:0]}};
                // halfword offset from bit 1 only
                if (addrLow[1]) begin
                    strobe = 4'b1100;
                end else begin
                    strobe = 4'b0011;
                end
            end
            default: begin
                shifted = data;
                strobe = 4'b1111;
            end
        endcase
    end

endmodule

// File: src/memLane.sv
`timescale 1ns/1ns

module memLane import memPkg::*; (
    input  logic    memRead,
    input  logic    memWrite,
    input  msize_t  size,
    input  logic    isUnsigned,
    input  word_t   addr,
    input  word_t   storeData,
    input  word_t   rspData,
    output logic    reqValid,
    output logic    reqWrite,
    output word_t   reqAddr,
    output word_t   reqData,
    output strobe_t reqStrobe,
    output msize_t  reqSize,
    output logic    reqUncached,
    output word_t   result
);

    word_t       shifted;
    strobe_t     strobe;
    logic [7:0]  loadByte;
    logic [15:0] loadHalf;

    storeFormat storeFmt (
        .addrLow (addr[1:0]),
        .size    (size),
        .data    (storeData),
        .shifted (shifted),
        .strobe  (strobe)
    );

    assign reqValid = memRead || memWrite;
    assign reqWrite = memWrite;
    assign reqAddr = addr;
    assign reqSize = size;
    assign reqUncached = addr[UNCACHED_BIT];

    // loads go out with no byte enables
    assign reqData = memWrite ? shifted : '0;
    assign reqStrobe = memWrite ? strobe : '0;

    assign loadByte = rspData[{addr[1:0], 3'b000} +: 8];
    assign loadHalf = addr[1] ? rspData[31:16] : rspData[15:0];

    // non-load lanes pass the alu result through
    always_comb begin
        if (!memRead) begin
            result = addr;
        end else begin
            case (size)
                SIZE_BYTE: result = isUnsigned ? {24'b0, loadByte} : {{24{loadByte[7]}}, loadByte};
                SIZE_HALF: result = isUnsigned ? {16'b0, loadHalf} : {{16{loadHalf[15]}}, loadHalf};
                default:   result = rspData;
            endcase
        end
    end

endmodule

// File: src/entryLatch.sv
`timescale 1ns/1ns

module entryLatch import memPkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   valid,
    input  logic   memRead [LANES],
    input  logic   memWrite [LANES],
    input  msize_t size [LANES],
    input  logic   isUnsigned [LANES],
    input  word_t  addr [LANES],
    input  word_t  storeData [LANES],
    input  ctype_t ctype [LANES],
    input  logic   regWrite [LANES],
    input  dest_t  dest [LANES],
    input  logic   done,
    output logic   groupValid,
    output logic   laneMemRead [LANES],
    output logic   laneMemWrite [LANES],
    output msize_t laneSize [LANES],
    output logic   laneUnsigned [LANES],
    output word_t  laneAddr [LANES],
    output word_t  laneStoreData [LANES],
    output logic   laneRegWrite [LANES],
    output dest_t  laneDest [LANES],
    output logic   excp
);

    logic             accept;
    logic             anyTrap;
    logic [LANES-1:0] trap;
    logic [LANES-1:0] squash;

    // one group in flight, so a held group blocks the next
    assign accept = valid && !groupValid;

    always_comb begin
        anyTrap = 1'b0;
        for (int i = 0; i < LANES; i++) begin
            trap[i] = isTrap(ctype[i]);
            anyTrap = anyTrap | trap[i];
        end
    end

    // a lane is squashed when any older lane traps
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            squash[i] = 1'b0;
            for (int j = i + 1; j < LANES; j++) begin
                squash[i] = squash[i] | trap[j];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            groupValid <= 1'b0;
            excp <= 1'b0;
        end else if (accept) begin
            groupValid <= 1'b1;
            excp <= anyTrap;
        end else if (done) begin
            groupValid <= 1'b0;
            excp <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            for (int i = 0; i < LANES; i++) begin
                laneMemRead[i] <= memRead[i] && !squash[i];
                laneMemWrite[i] <= memWrite[i] && !squash[i];
                laneRegWrite[i] <= regWrite[i] && !squash[i];
                laneSize[i] <= size[i];
                laneUnsigned[i] <= isUnsigned[i];
                laneAddr[i] <= addr[i];
                laneStoreData[i] <= storeData[i];
                laneDest[i] <= dest[i];
            end
        end
    end

endmodule

// File: src/dbusSequencer.sv
`timescale 1ns/1ns

module dbusSequencer import memPkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    groupValid,
    input  logic    reqValid [LANES],
    input  logic    reqWrite [LANES],
    input  word_t   reqAddr [LANES],
    input  word_t   reqData [LANES],
    input  strobe_t reqStrobe [LANES],
    input  msize_t  reqSize [LANES],
    input  logic    reqUncached [LANES],
    input  logic    busDataOk,
    input  word_t   busRdata,
    output logic    busValid,
    output logic    busWrite,
    output word_t   busAddr,
    output word_t   busData,
    output strobe_t busStrobe,
    output msize_t  busSize,
    output logic    busUncached,
    output word_t   rspData [LANES],
    output logic    done,
    output logic    busy,
    output logic    wbValid
);

    // started is low only in the first cycle of a group
    logic                 started;
    logic [LANES-1:0]     pending;
    logic [LANES-1:0]     pendNow;
    logic [LANE_BITS-1:0] lanePtr;
    logic                 complete;

    // fresh group takes its mask straight from the lane requests
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            pendNow[i] = started ? pending[i] : reqValid[i];
        end
    end

    // oldest lane first, so the highest pending index wins
    always_comb begin
        lanePtr = '0;
        for (int i = 0; i < LANES; i++) begin
            if (pendNow[i]) begin
                lanePtr = LANE_BITS'(i);
            end
        end
    end

    assign busValid = groupValid && (|pendNow);
    assign complete = busValid && busDataOk;

    // nothing left to serve, release the group
    assign done = groupValid && !(|pendNow);
    assign wbValid = done;
    assign busy = groupValid;

    // current lane on the bus, stable while the pointer holds
    assign busWrite = reqWrite[lanePtr];
    assign busAddr = reqAddr[lanePtr];
    assign busData = reqData[lanePtr];
    assign busStrobe = reqStrobe[lanePtr];
    assign busSize = reqSize[lanePtr];
    assign busUncached = reqUncached[lanePtr];

    always_ff @(posedge clk) begin
        if (reset) begin
            started <= 1'b0;
            pending <= '0;
        end else if (done) begin
            started <= 1'b0;
            pending <= '0;
        end else if (groupValid) begin
            started <= 1'b1;
            pending <= pendNow;
            // retire the lane just completed
            if (complete) begin
                pending[lanePtr] <= 1'b0;
            end
        end
    end

    // read data held per lane until writeback
    always_ff @(posedge clk) begin
        if (complete) begin
            rspData[lanePtr] <= busRdata;
        end
    end

endmodule

// File: src/memStage.sv
`timescale 1ns/1ns

module memStage import memPkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    valid,
    input  logic    memRead [LANES],
    input  logic    memWrite [LANES],
    input  msize_t  size [LANES],
    input  logic    isUnsigned [LANES],
    input  word_t   addr [LANES],
    input  word_t   storeData [LANES],
    input  ctype_t  ctype [LANES],
    input  logic    regWrite [LANES],
    input  dest_t   dest [LANES],
    output logic    busy,
    output logic    busValid,
    output logic    busWrite,
    output word_t   busAddr,
    output word_t   busData,
    output strobe_t busStrobe,
    output msize_t  busSize,
    output logic    busUncached,
    input  logic    busDataOk,
    input  word_t   busRdata,
    output logic    wbValid,
    output logic    wbRegWrite [LANES],
    output dest_t   wbDest [LANES],
    output word_t   wbData [LANES],
    output logic    excp
);

    logic    groupValid;
    logic    done;
    logic    laneMemRead [LANES];
    logic    laneMemWrite [LANES];
    msize_t  laneSize [LANES];
    logic    laneUnsigned [LANES];
    word_t   laneAddr [LANES];
    word_t   laneStoreData [LANES];

    // per-lane requests toward the sequencer
    logic    reqValid [LANES];
    logic    reqWrite [LANES];
    word_t   reqAddr [LANES];
    word_t   reqData [LANES];
    strobe_t reqStrobe [LANES];
    msize_t  reqSize [LANES];
    logic    reqUncached [LANES];
    word_t   rspData [LANES];

    entryLatch latch (
        .clk           (clk),
        .reset         (reset),
        .valid         (valid),
        .memRead       (memRead),
        .memWrite      (memWrite),
        .size          (size),
        .isUnsigned    (isUnsigned),
        .addr          (addr),
        .storeData     (storeData),
        .ctype         (ctype),
        .regWrite      (regWrite),
        .dest          (dest),
        .done          (done),
        .groupValid    (groupValid),
        .laneMemRead   (laneMemRead),
        .laneMemWrite  (laneMemWrite),
        .laneSize      (laneSize),
        .laneUnsigned  (laneUnsigned),
        .laneAddr      (laneAddr),
        .laneStoreData (laneStoreData),
        .laneRegWrite  (wbRegWrite),
        .laneDest      (wbDest),
        .excp          (excp)
    );

    for (genvar i = 0; i < LANES; i++) begin : genLane
        memLane lane (
            .memRead     (laneMemRead[i]),
            .memWrite    (laneMemWrite[i]),
            .size        (laneSize[i]),
            .isUnsigned  (laneUnsigned[i]),
            .addr        (laneAddr[i]),
            .storeData   (laneStoreData[i]),
            .rspData     (rspData[i]),
            .reqValid    (reqValid[i]),
            .reqWrite    (reqWrite[i]),
            .reqAddr     (reqAddr[i]),
            .reqData     (reqData[i]),
            .reqStrobe   (reqStrobe[i]),
            .reqSize     (reqSize[i]),
            .reqUncached (reqUncached[i]),
            .result      (wbData[i])
        );
    end

    dbusSequencer sequencer (
        .clk         (clk),
        .reset       (reset),
        .groupValid  (groupValid),
        .reqValid    (reqValid),
        .reqWrite    (reqWrite),
        .reqAddr     (reqAddr),
        .reqData     (reqData),
        .reqStrobe   (reqStrobe),
        .reqSize     (reqSize),
        .reqUncached (reqUncached),
        .busDataOk   (busDataOk),
        .busRdata    (busRdata),
        .busValid    (busValid),
        .busWrite    (busWrite),
        .busAddr     (busAddr),
        .busData     (busData),
        .busStrobe   (busStrobe),
        .busSize     (busSize),
        .busUncached (busUncached),
        .rspData     (rspData),
        .done        (done),
        .busy        (busy),
        .wbValid     (wbValid)
    );

endmodule

// File: tb/memStage_checker.sv
`timescale 1ns/1ns

module memStage_checker import memPkg::*; (
    input logic    clk,
    input logic    reset,
    input logic    busValid,
    input logic    busDataOk,
    input logic    busWrite,
    input word_t   busAddr,
    input word_t   busData,
    input strobe_t busStrobe,
    input msize_t  busSize,
    input logic    busUncached,
    input logic    wbValid
);

    int failures = 0;

    // a request holds still until the slave answers
    property heldRequest;
        @(posedge clk) disable iff (reset)
        busValid && !busDataOk |=> busValid && $stable(busWrite) && $stable(busAddr)
            && $stable(busData) && $stable(busStrobe) && $stable(busSize)
            && $stable(busUncached);
    endproperty

    assert property (heldRequest)
    else begin
        failures++;
        $error("bus request changed or dropped before busDataOk");
    end

    assert property (@(posedge clk) disable iff (reset) wbValid |=> !wbValid)
    else begin
        failures++;
        $error("wbValid longer than one cycle");
    end

    assert property (@(posedge clk) reset |=> !busValid)
    else begin
        failures++;
        $error("busValid high right after reset");
    end

endmodule

bind dbusSequencer memStage_checker protocolCheck (.*);

// File: tb/memStage_tb.sv
`timescale 1ns/1ns

module memStage_tb import memPkg::*; ();

    logic    clk;
    logic    reset;
    logic    valid;
    logic    memRead [LANES];
    logic    memWrite [LANES];
    msize_t  size [LANES];
    logic    isUnsigned [LANES];
    word_t   addr [LANES];
    word_t   storeData [LANES];
    ctype_t  ctype [LANES];
    logic    regWrite [LANES];
    dest_t   dest [LANES];
    logic    busy;
    logic    busValid;
    logic    busWrite;
    logic    busUncached;
    logic    busDataOk;
    logic    wbValid;
    logic    excp;
    word_t   busAddr;
    word_t   busData;
    word_t   busRdata;
    strobe_t busStrobe;
    msize_t  busSize;
    logic    wbRegWrite [LANES];
    dest_t   wbDest [LANES];
    word_t   wbData [LANES];

    // bus slave image, 256 words
    word_t   mem [256];
    word_t   seenAddr [$];
    word_t   seenData [$];
    strobe_t seenStrobe [$];
    logic    seenUncached [$];
    logic    seenWrite [$];
    msize_t  seenSize [$];
    logic    slowBus;
    int      checks;
    int      errors;
    int      timeouts;

    memStage memStage_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // answers each request after a random delay, logs what it saw
    initial begin : busModel
        int holdLeft;
        holdLeft = -1;
        busDataOk = 1'b0;
        busRdata = '0;
        forever begin
            @(posedge clk);
            #1;
            busDataOk = 1'b0;
            if (busValid && holdLeft < 0) begin
                holdLeft = int'($urandom % 4) + (slowBus ? 6 : 0);
            end
            if (busValid && holdLeft == 0) begin
                seenAddr.push_back(busAddr);
                seenData.push_back(busData);
                seenStrobe.push_back(busStrobe);
                seenUncached.push_back(busUncached);
                seenWrite.push_back(busWrite);
                seenSize.push_back(busSize);
                busRdata = mem[busAddr[9:2]];
                for (int b = 0; b < 4; b++) begin
                    if (busWrite && busStrobe[b]) begin
                        mem[busAddr[9:2]][8*b +: 8] = busData[8*b +: 8];
                    end
                end
                busDataOk = 1'b1;
                holdLeft = -1;
            end else if (holdLeft > 0) begin
                holdLeft--;
            end
        end
    end

    task automatic checkWord(string name, word_t got, word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkStrobe(string name, strobe_t got, strobe_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic checkBit(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic checkSize(string name, msize_t got, msize_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic checkDest(string name, dest_t got, dest_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    function automatic bit requestsSeen(int n);
        checks++;
        if (seenAddr.size() == n) begin
            return 1'b1;
        end
        errors++;
        $display("error at %0t: expected %0d bus requests, saw %0d", $time, n, seenAddr.size());
        return 1'b0;
    endfunction

    // expected memory word after a store lands at its offset
    function automatic word_t placeStore(word_t old, int off, msize_t sz, word_t val);
        word_t r;
        r = old;
        case (sz)
            SIZE_BYTE: r[8*off +: 8] = val[7:0];
            SIZE_HALF: r[8*off +: 16] = val[15:0];
            default:   r = val;
        endcase
        return r;
    endfunction

    function automatic word_t loadExpect(word_t w, int off, msize_t sz, logic uns);
        word_t s;
        s = w >> (8 * off);
        if (sz == SIZE_BYTE) begin
            return uns ? (s & 32'h0000_00ff) : word_t'($signed(s[7:0]));
        end
        return uns ? (s & 32'h0000_ffff) : word_t'($signed(s[15:0]));
    endfunction

    task automatic setLane(int i, logic rd, logic wr, msize_t sz, logic uns, word_t a,
                           word_t sd, ctype_t ct, logic rw, dest_t d);
        memRead[i] = rd;
        memWrite[i] = wr;
        size[i] = sz;
        isUnsigned[i] = uns;
        addr[i] = a;
        storeData[i] = sd;
        ctype[i] = ct;
        regWrite[i] = rw;
        dest[i] = d;
    endtask

    task automatic startGroup();
        valid = 1'b0;
        seenAddr.delete();
        seenData.delete();
        seenStrobe.delete();
        seenUncached.delete();
        seenWrite.delete();
        seenSize.delete();
        for (int i = 0; i < LANES; i++) begin
            setLane(i, 1'b0, 1'b0, SIZE_WORD, 1'b0, '0, '0, CT_NONE, 1'b0, '0);
        end
    endtask

    // waits out busy, then holds valid across one accepting edge
    task automatic sendGroup();
        int n;
        n = 0;
        while (busy && n < 100) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (busy) begin
            timeouts++;
            $display("timeout at %0t: stage stayed busy, group not accepted", $time);
        end
        valid = 1'b1;
        @(posedge clk);
        #1;
        valid = 1'b0;
    endtask

    task automatic waitWb();
        int n;
        n = 0;
        while (!wbValid && n < 100) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!wbValid) begin
            timeouts++;
            $display("timeout at %0t: no writeback pulse after %0d cycles", $time, n);
        end
    endtask

    task automatic storesAtEachOffset();
        word_t  a;
        word_t  old;
        word_t  val;
        msize_t sz;
        int     off;
        for (int k = 0; k < 7; k++) begin
            sz = (k < 4) ? SIZE_BYTE : ((k < 6) ? SIZE_HALF : SIZE_WORD);
            off = (k < 4) ? k : ((k < 6) ? (k - 4) * 2 : 0);
            a = 32'h0000_0100 + word_t'(4 * k + off);
            val = $urandom;
            old = mem[a[9:2]];
            startGroup();
            setLane(1, 1'b0, 1'b1, sz, 1'b0, a, val, CT_NONE, 1'b0, 5'd0);
            setLane(0, 1'b0, 1'b0, SIZE_WORD, 1'b0, 32'h55, '0, CT_NONE, 1'b1, 5'd3);
            sendGroup();
            waitWb();
            if (requestsSeen(1)) begin
                checkWord("busAddr", seenAddr[0], a);
                checkBit("busWrite", seenWrite[0], 1'b1);
                checkSize("busSize", seenSize[0], sz);
                case (sz)
                    SIZE_BYTE: checkWord("busData", seenData[0], {4{val[7:0]}});
                    SIZE_HALF: checkWord("busData", seenData[0], {2{val[15:0]}});
                    default:   checkWord("busData", seenData[0], val);
                endcase
                // one byte, an aligned halfword pair, or the whole word
                case (sz)
                    SIZE_BYTE: checkStrobe("busStrobe", seenStrobe[0], strobe_t'(4'b0001 << off));
                    SIZE_HALF: checkStrobe("busStrobe", seenStrobe[0], off >= 2 ? 4'b1100 : 4'b0011);
                    default:   checkStrobe("busStrobe", seenStrobe[0], 4'b1111);
                endcase
                checkBit("busUncached", seenUncached[0], 1'b0);
            end
            checkWord("wbData[0]", wbData[0], 32'h55);
            checkDest("wbDest[0]", wbDest[0], 5'd3);
            checkWord("mem after store", mem[a[9:2]], placeStore(old, off, sz, val));
        end
    endtask

    task automatic loadsWithExtension();
        msize_t sz;
        int     off;
        mem[8'h80] = 32'h80f1_7f22;
        for (int k = 0; k < 6; k++) begin
            for (int u = 0; u < 2; u++) begin
                sz = (k < 4) ? SIZE_BYTE : SIZE_HALF;
                off = (k < 4) ? k : (k - 4) * 2;
                startGroup();
                setLane(1, 1'b1, 1'b0, sz, u[0], 32'h200 + word_t'(off), '0, CT_NONE, 1'b1, 5'd9);
                setLane(0, 1'b0, 1'b0, SIZE_WORD, 1'b0, 32'hc0de_0000 + word_t'(k), '0, CT_NONE,
                        1'b1, 5'd4);
                sendGroup();
                waitWb();
                checkWord("wbData[1]", wbData[1], loadExpect(32'h80f1_7f22, off, sz, u[0]));
                checkWord("wbData[0]", wbData[0], 32'hc0de_0000 + word_t'(k));
                checkBit("wbRegWrite[1]", wbRegWrite[1], 1'b1);
                checkDest("wbDest[1]", wbDest[1], 5'd9);
                checkDest("wbDest[0]", wbDest[0], 5'd4);
            end
        end
    endtask

    // lane 0 reads back what lane 1 writes, so the order shows in the data
    task automatic bothLanesInOrder();
        startGroup();
        setLane(1, 1'b0, 1'b1, SIZE_WORD, 1'b0, 32'h300, 32'h1234_abcd, CT_NONE, 1'b0, 5'd0);
        setLane(0, 1'b1, 1'b0, SIZE_WORD, 1'b0, 32'h300, '0, CT_NONE, 1'b1, 5'd7);
        sendGroup();
        waitWb();
        if (requestsSeen(2)) begin
            checkStrobe("first busStrobe", seenStrobe[0], 4'b1111);
            checkStrobe("second busStrobe", seenStrobe[1], 4'b0000);
            checkBit("first busWrite", seenWrite[0], 1'b1);
            checkBit("second busWrite", seenWrite[1], 1'b0);
        end
        checkWord("wbData[1]", wbData[1], 32'h300);
        checkWord("wbData[0]", wbData[0], 32'h1234_abcd);
        checkDest("wbDest[0]", wbDest[0], 5'd7);
        checkBit("excp", excp, 1'b0);
    endtask

    task automatic squashOnTrap();
        word_t old;
        for (int t = 0; t < 2; t++) begin
            old = mem[8'he0];
            startGroup();
            setLane(1, 1'b0, 1'b0, SIZE_WORD, 1'b0, 32'h0bad_0000, '0,
                    t == 1 ? CT_ERET : CT_EXCEPTION, 1'b1, 5'd1);
            setLane(0, 1'b0, 1'b1, SIZE_WORD, 1'b0, 32'h380, 32'hdead_beef, CT_NONE, 1'b1, 5'd2);
            sendGroup();
            waitWb();
            void'(requestsSeen(0));
            checkBit("wbRegWrite[0]", wbRegWrite[0], 1'b0);
            checkBit("wbRegWrite[1]", wbRegWrite[1], 1'b1);
            checkBit("excp", excp, 1'b1);
            checkWord("mem at 0x380", mem[8'he0], old);
        end
        // trap on the younger lane leaves the older one alone
        startGroup();
        setLane(1, 1'b1, 1'b0, SIZE_WORD, 1'b0, 32'h200, '0, CT_NONE, 1'b1, 5'd5);
        setLane(0, 1'b0, 1'b0, SIZE_WORD, 1'b0, 32'h44, '0, CT_EXCEPTION, 1'b1, 5'd6);
        sendGroup();
        waitWb();
        void'(requestsSeen(1));
        checkBit("wbRegWrite[1]", wbRegWrite[1], 1'b1);
        checkWord("wbData[1]", wbData[1], 32'h80f1_7f22);
        checkBit("excp", excp, 1'b1);
    endtask

    task automatic heldUnderBackPressure();
        int n;
        slowBus = 1'b1;
        startGroup();
        setLane(1, 1'b1, 1'b0, SIZE_WORD, 1'b0, 32'h2000_0200, '0, CT_NONE, 1'b1, 5'd10);
        setLane(0, 1'b0, 1'b1, SIZE_WORD, 1'b0, 32'h2000_0384, 32'h0f0f_1234, CT_NONE,
                1'b0, 5'd0);
        sendGroup();
        // garbage offered while the group is held
        n = 0;
        while (!wbValid && n < 200) begin
            checkBit("busy", busy, 1'b1);
            valid = 1'b1;
            setLane(1, 1'b1, 1'b1, SIZE_BYTE, 1'b1, $urandom, $urandom, CT_ERET, 1'b1, 5'd31);
            setLane(0, 1'b1, 1'b1, SIZE_HALF, 1'b0, $urandom, $urandom, CT_ERET, 1'b1, 5'd30);
            @(posedge clk);
            #1;
            n++;
        end
        if (!wbValid) begin
            timeouts++;
            $display("timeout at %0t: slow group never reached writeback", $time);
        end
        checkWord("wbData[1]", wbData[1], 32'h80f1_7f22);
        checkWord("wbData[0]", wbData[0], 32'h2000_0384);
        checkDest("wbDest[1]", wbDest[1], 5'd10);
        checkBit("excp", excp, 1'b0);
        if (requestsSeen(2)) begin
            checkBit("busUncached", seenUncached[0], 1'b1);
            checkBit("busUncached", seenUncached[1], 1'b1);
        end
        checkWord("mem at 0x384", mem[8'he1], 32'h0f0f_1234);
        startGroup();
        setLane(1, 1'b1, 1'b0, SIZE_HALF, 1'b0, 32'h2000_0202, '0, CT_NONE, 1'b1, 5'd11);
        setLane(0, 1'b0, 1'b0, SIZE_WORD, 1'b0, 32'h77, '0, CT_NONE, 1'b1, 5'd12);
        sendGroup();
        waitWb();
        checkWord("wbData[1]", wbData[1], 32'hffff_80f1);
        checkWord("wbData[0]", wbData[0], 32'h77);
        checkDest("wbDest[1]", wbDest[1], 5'd11);
        checkDest("wbDest[0]", wbDest[0], 5'd12);
        checkBit("excp", excp, 1'b0);
        slowBus = 1'b0;
    endtask

    initial begin
        void'($urandom(32'h4b756c86));
        checks = 0;
        errors = 0;
        timeouts = 0;
        slowBus = 1'b0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = {8'(i) ^ 8'h5a, 8'(i), ~8'(i), 8'(i) ^ 8'hc3};
        end
        reset = 1'b1;
        startGroup();
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        storesAtEachOffset();
        loadsWithExtension();
        bothLanesInOrder();
        squashOnTrap();
        heldUnderBackPressure();
        repeat (2) @(posedge clk);
        $display("checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
                 checks, errors, timeouts, memStage_i.sequencer.protocolCheck.failures);
        if (errors == 0 && timeouts == 0 && memStage_i.sequencer.protocolCheck.failures == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: sources.f
src/memPkg.sv
src/storeFormat.sv
src/memLane.sv
src/entryLatch.sv
src/dbusSequencer.sv
src/memStage.sv
tb/memStage_checker.sv
tb/memStage_tb.sv

// File: Makefile
TOP = memStage_tb

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f
	./obj_dir/V$(TOP) +verilator+error+limit+100 > sim.log 2>&1
	! grep -qF '** FAIL **' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
